// File: Makefile
# Verilator build and run of the tiny_core testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tiny_core_tb
FILELIST  ?= tiny_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || { echo "run did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/tiny_core.sv
// tiny_core top level: in-order decode, execute and commit pipeline around one register file
`timescale 1ns/1ns
`default_nettype none

module tiny_core import tiny_core_pkg::*; #(
  parameter logic [XLEN-1:0] BootAddr = 'h8000_0000
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic [ILEN-1:0] instr_i,
  input  logic            instr_valid_i,
  output logic            instr_ready_o,
  output result_entry_t   commit_o,
  output logic            commit_valid_o,
  input  logic            commit_ready_i
);

  // ------------------------------------------------------------------
  // inter-stage wiring
  // ------------------------------------------------------------------
  issue_entry_t          issue_d, issue_q;
  logic                  issue_valid_d, issue_ready_d;
  logic                  issue_valid_q, issue_ready_q;
  result_entry_t         result_d, result_q;
  logic                  result_valid_d, result_ready_d;
  logic                  result_valid_q, result_ready_q;
  logic [REG_ADDR_W-1:0] raddr_a, raddr_b;
  logic [XLEN-1:0]       rdata_a, rdata_b;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;
  logic                  rf_we;
  logic                  release_valid;
  logic [REG_ADDR_W-1:0] release_rd;

  tiny_core_decode #(.BootAddr(BootAddr)) i_decode (
    .clk_i, .rst_ni, .instr_i, .instr_valid_i, .instr_ready_o,
    .raddr_a_o(raddr_a), .raddr_b_o(raddr_b), .rdata_a_i(rdata_a), .rdata_b_i(rdata_b),
    .issue_o(issue_d), .issue_valid_o(issue_valid_d), .issue_ready_i(issue_ready_d),
    .release_valid_i(release_valid), .release_rd_i(release_rd)
  );

  tiny_core_pipe_reg #(.payload_t(issue_entry_t)) i_issue_reg (
    .clk_i, .rst_ni,
    .valid_i(issue_valid_d), .ready_o(issue_ready_d), .data_i(issue_d),
    .valid_o(issue_valid_q), .ready_i(issue_ready_q), .data_o(issue_q)
  );

  tiny_core_execute i_execute (
    .issue_i(issue_q), .issue_valid_i(issue_valid_q), .issue_ready_o(issue_ready_q),
    .result_o(result_d), .result_valid_o(result_valid_d), .result_ready_i(result_ready_d)
  );

  tiny_core_pipe_reg #(.payload_t(result_entry_t)) i_result_reg (
    .clk_i, .rst_ni,
    .valid_i(result_valid_d), .ready_o(result_ready_d), .data_i(result_d),
    .valid_o(result_valid_q), .ready_i(result_ready_q), .data_o(result_q)
  );

  tiny_core_commit i_commit (
    .result_i(result_q), .result_valid_i(result_valid_q), .result_ready_o(result_ready_q),
    .commit_o, .commit_valid_o, .commit_ready_i,
    .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata), .rf_we_o(rf_we),
    .release_valid_o(release_valid), .release_rd_o(release_rd)
  );

  tiny_core_regfile i_regfile (
    .clk_i, .rst_ni,
    .raddr_a_i(raddr_a), .raddr_b_i(raddr_b), .rdata_a_o(rdata_a), .rdata_b_o(rdata_b),
    .waddr_i(rf_waddr), .wdata_i(rf_wdata), .we_i(rf_we)
  );

endmodule

`default_nettype wire

// File: design/tiny_core_commit.sv
// commit stage: retires results in order, writes back and releases scoreboard entries
`timescale 1ns/1ns
`default_nettype none

module tiny_core_commit import tiny_core_pkg::*; (
  input  result_entry_t         result_i,
  input  logic                  result_valid_i,
  output logic                  result_ready_o,
  output result_entry_t         commit_o,
  output logic                  commit_valid_o,
  input  logic                  commit_ready_i,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic [XLEN-1:0]       rf_wdata_o,
  output logic                  rf_we_o,
  output logic                  release_valid_o,
  output logic [REG_ADDR_W-1:0] release_rd_o
);

  logic retire;
  logic do_write;

  // report stays on the outputs until the environment takes it
  assign commit_o       = result_i;
  assign commit_valid_o = result_valid_i;
  assign result_ready_o = commit_ready_i;

  assign retire   = result_valid_i & commit_ready_i;
  assign do_write = retire & result_i.writes_rd;

  // write-back, x0 filtered in the register file
  assign rf_we_o    = do_write;
  assign rf_waddr_o = result_i.rd;
  assign rf_wdata_o = result_i.result;

  // same edge as the write so decode sees the new value next cycle
  assign release_valid_o = do_write;
  assign release_rd_o    = result_i.rd;

endmodule

`default_nettype wire

// File: design/tiny_core_decode.sv
// decode stage: accepts instructions, keeps the pc, reads operands and tracks pending writes
`timescale 1ns/1ns
`default_nettype none

module tiny_core_decode import tiny_core_pkg::*; #(
  parameter logic [XLEN-1:0] BootAddr = '0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [ILEN-1:0]       instr_i,
  input  logic                  instr_valid_i,
  output logic                  instr_ready_o,
  output logic [REG_ADDR_W-1:0] raddr_a_o,
  output logic [REG_ADDR_W-1:0] raddr_b_o,
  input  logic [XLEN-1:0]       rdata_a_i,
  input  logic [XLEN-1:0]       rdata_b_i,
  output issue_entry_t          issue_o,
  output logic                  issue_valid_o,
  input  logic                  issue_ready_i,
  input  logic                  release_valid_i,
  input  logic [REG_ADDR_W-1:0] release_rd_i
);

  logic [XLEN-1:0]    pc_q;
  logic [NR_REGS-1:0] pending_q, pending_d;
  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  logic               is_op;
  logic               illegal;
  logic               hazard;
  logic               fire;
  alu_op_e            alu_op;

  assign opcode    = instr_i[6:0];
  assign funct3    = instr_i[14:12];
  assign funct7    = instr_i[31:25];
  assign is_op     = (opcode == OPCODE_OP);
  assign raddr_a_o = instr_i[19:15];
  assign raddr_b_o = instr_i[24:20];

  // ------------------------------------------------------------------
  // opcode and funct decoding
  // ------------------------------------------------------------------
  always_comb begin
    illegal = 1'b0;
    alu_op  = ALU_ADD;
    case (funct3)
      3'b000: alu_op = (is_op && funct7 == 7'b0100000) ? ALU_SUB : ALU_ADD;
      3'b010: alu_op = ALU_SLT;
      3'b100: alu_op = ALU_XOR;
      3'b110: alu_op = ALU_OR;
      3'b111: alu_op = ALU_AND;
      default: illegal = 1'b1;
    endcase
    if (is_op && !(funct7 == 7'b0000000 || (funct7 == 7'b0100000 && funct3 == 3'b000))) begin
      illegal = 1'b1;
    end
    if (!is_op && opcode != OPCODE_OP_IMM) begin
      illegal = 1'b1;
    end
  end

  assign issue_o.alu_op    = alu_op;
  assign issue_o.operand_a = rdata_a_i;
  // sign-extended I-type immediate for OP-IMM
  assign issue_o.operand_b = is_op ? rdata_b_i : {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign issue_o.rd        = instr_i[11:7];
  assign issue_o.writes_rd = ~illegal;
  assign issue_o.illegal   = illegal;
  assign issue_o.pc        = pc_q;
  assign issue_o.instr     = instr_i;

  // sources must be settled, and rd must not already have a write in flight
  assign hazard = ~illegal & (pending_q[raddr_a_o]
                             | (is_op & pending_q[raddr_b_o])
                             | pending_q[issue_o.rd]);

  assign issue_valid_o = instr_valid_i & ~hazard;
  assign instr_ready_o = issue_ready_i & ~hazard;
  assign fire          = instr_valid_i & instr_ready_o;

  // ------------------------------------------------------------------
  // scoreboard
  // ------------------------------------------------------------------
  always_comb begin
    pending_d = pending_q;
    if (release_valid_i) begin
      pending_d[release_rd_i] = 1'b0;
    end
    if (fire && issue_o.writes_rd && issue_o.rd != '0) begin
      pending_d[issue_o.rd] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q      <= BootAddr;
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
      if (fire) begin
        pc_q <= pc_q + XLEN'(4);
      end
    end
  end

endmodule

`default_nettype wire

// File: design/tiny_core_execute.sv
// execute stage: combinational integer ALU between the issue and result pipeline registers
`timescale 1ns/1ns
`default_nettype none

module tiny_core_execute import tiny_core_pkg::*; (
  input  issue_entry_t  issue_i,
  input  logic          issue_valid_i,
  output logic          issue_ready_o,
  output result_entry_t result_o,
  output logic          result_valid_o,
  input  logic          result_ready_i
);

  logic [XLEN-1:0] alu_result;
  logic            less_than;

  // no state here, handshake passes straight through
  assign result_valid_o = issue_valid_i;
  assign issue_ready_o  = result_ready_i;

  assign less_than = $signed(issue_i.operand_a) < $signed(issue_i.operand_b);

  always_comb begin
    case (issue_i.alu_op)
      ALU_ADD: alu_result = issue_i.operand_a + issue_i.operand_b;
      ALU_SUB: alu_result = issue_i.operand_a - issue_i.operand_b;
      ALU_AND: alu_result = issue_i.operand_a & issue_i.operand_b;
      ALU_OR:  alu_result = issue_i.operand_a | issue_i.operand_b;
      ALU_XOR: alu_result = issue_i.operand_a ^ issue_i.operand_b;
      ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, less_than};
      default: alu_result = '0;
    endcase
  end

  // ------------------------------------------------------------------
  // result entry
  // ------------------------------------------------------------------
  always_comb begin
    result_o.pc        = issue_i.pc;
    result_o.rd        = issue_i.rd;
    result_o.writes_rd = issue_i.writes_rd & ~issue_i.illegal;
    result_o.illegal   = issue_i.illegal;
    result_o.result    = alu_result;
    result_o.tval      = '0;
    // trap carries the instruction word and writes nothing
    if (issue_i.illegal) begin
      result_o.result = '0;
      result_o.tval   = XLEN'(issue_i.instr);
    end
  end

endmodule

`default_nettype wire

// File: design/tiny_core_pipe_reg.sv
// one-entry valid/ready pipeline register, instantiated between tiny_core stages
`timescale 1ns/1ns
`default_nettype none

module tiny_core_pipe_reg import tiny_core_pkg::*; #(
  parameter type payload_t = issue_entry_t
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     full_q;
  payload_t data_q;

  // free slot, or the held item leaves this cycle
  assign ready_o = ~full_q | ready_i;
  assign valid_o = full_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (ready_o) begin
      full_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: design/tiny_core_pkg.sv
// shared widths, opcodes and stage payload structs, imported by every tiny_core stage
`default_nettype none

package tiny_core_pkg;

  // ------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------
  localparam int unsigned XLEN       = 32;
  localparam int unsigned ILEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NR_REGS    = 32;

  // mcause value for an illegal instruction
  localparam logic [XLEN-1:0] ILLEGAL_INSTR_CAUSE = 'd2;

  // major opcodes handled by decode
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  // decode -> execute
  typedef struct packed {
    alu_op_e                 alu_op;
    logic [XLEN-1:0]         operand_a;
    logic [XLEN-1:0]         operand_b;
    logic [REG_ADDR_W-1:0]   rd;
    logic                    writes_rd;
    logic                    illegal;
    logic [XLEN-1:0]         pc;
    logic [ILEN-1:0]         instr;
  } issue_entry_t;

  // execute -> commit, also the retire report
  typedef struct packed {
    logic [XLEN-1:0]         pc;
    logic [REG_ADDR_W-1:0]   rd;
    logic                    writes_rd;
    logic                    illegal;
    logic [XLEN-1:0]         result;
    logic [XLEN-1:0]         tval;
  } result_entry_t;

endpackage

`default_nettype wire

// File: design/tiny_core_regfile.sv
// integer register file with two async read ports and one write port, x0 hardwired to zero
`timescale 1ns/1ns
`default_nettype none

module tiny_core_regfile import tiny_core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [REG_ADDR_W-1:0] raddr_a_i,
  input  logic [REG_ADDR_W-1:0] raddr_b_i,
  output logic [XLEN-1:0]       rdata_a_o,
  output logic [XLEN-1:0]       rdata_b_o,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i,
  input  logic                  we_i
);

  // x1 .. x31 only
  logic [XLEN-1:0] regs_q [NR_REGS-1:1];

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < NR_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      // writes to x0 are dropped
      regs_q[waddr_i] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

// File: tiny_core.f
design/tiny_core_pkg.sv
design/tiny_core_pipe_reg.sv
design/tiny_core_regfile.sv
design/tiny_core_decode.sv
design/tiny_core_execute.sv
design/tiny_core_commit.sv
design/tiny_core.sv
verification/tiny_core_chk.sv
verification/tiny_core_tb.sv

// File: verification/tiny_core_chk.sv
// handshake assertions bound into each tiny_core instance by the bind below
`timescale 1ns/1ns
`default_nettype none

module tiny_core_chk import tiny_core_pkg::*; (
  input logic            clk_i,
  input logic            rst_ni,
  input logic [ILEN-1:0] instr_i,
  input logic            instr_valid_i,
  input logic            instr_ready_o,
  input result_entry_t   commit_o,
  input logic            commit_valid_o,
  input logic            commit_ready_i
);

  // a report that is not taken stays put
  commit_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_o && !commit_ready_i |=> commit_valid_o && commit_o == $past(commit_o))
    else $error("commit report changed while commit_ready_i was low");

  commit_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !commit_valid_o)
    else $error("commit_valid_o high during reset");

  // an offered word stays on the port until decode takes it
  instr_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_i && !instr_ready_o |=> instr_valid_i && $stable(instr_i))
    else $error("instr_i changed before the offered instruction was taken");

endmodule

bind tiny_core tiny_core_chk i_chk (
  .clk_i(clk_i), .rst_ni(rst_ni), .instr_i(instr_i), .instr_valid_i(instr_valid_i),
  .instr_ready_o(instr_ready_o), .commit_o(commit_o), .commit_valid_o(commit_valid_o),
  .commit_ready_i(commit_ready_i)
);

`default_nettype wire

// File: verification/tiny_core_tb.sv
// testbench for tiny_core: streams an instruction table through the core and checks each retire
`timescale 1ns/1ns
`default_nettype none

module tiny_core_tb import tiny_core_pkg::*; ();

  localparam logic [XLEN-1:0] BOOT_ADDR    = 32'h0000_1000;
  localparam int              RESET_CYCLES = 8;

  // instruction kinds, register-register first
  localparam logic [3:0] K_ADD  = 4'd0;
  localparam logic [3:0] K_SUB  = 4'd1;
  localparam logic [3:0] K_AND  = 4'd2;
  localparam logic [3:0] K_OR   = 4'd3;
  localparam logic [3:0] K_XOR  = 4'd4;
  localparam logic [3:0] K_SLT  = 4'd5;
  localparam logic [3:0] K_ADDI = 4'd6;
  localparam logic [3:0] K_ANDI = 4'd7;
  localparam logic [3:0] K_ORI  = 4'd8;
  localparam logic [3:0] K_XORI = 4'd9;
  localparam logic [3:0] K_SLTI = 4'd10;
  localparam logic [3:0] K_LOAD = 4'd11;

  typedef struct packed {
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
  } test_t;

  logic            clk_i;
  logic            rst_ni;
  logic [ILEN-1:0] instr_i;
  logic            instr_valid_i;
  logic            instr_ready_o;
  result_entry_t   commit_o;
  logic            commit_valid_o;
  logic            commit_ready_i;

  test_t           tests[$];
  string           names[$];
  logic [31:0]     words[$];
  result_entry_t   expected[$];
  int              sent;
  int              retired;
  int              cycles;
  int              limit;
  logic            took_any;
  logic [31:0]     lfsr;
  logic            gap;
  logic            stall;

  tiny_core #(.BootAddr(BOOT_ADDR)) DUT (
    .clk_i(clk_i), .rst_ni(rst_ni), .instr_i(instr_i), .instr_valid_i(instr_valid_i),
    .instr_ready_o(instr_ready_o), .commit_o(commit_o), .commit_valid_o(commit_valid_o),
    .commit_ready_i(commit_ready_i)
  );

  always #20 clk_i = ~clk_i;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [2:0] funct3_of(logic [3:0] kind);
    case (kind)
      K_SLT, K_SLTI, K_LOAD: return 3'b010;
      K_XOR, K_XORI:         return 3'b100;
      K_OR, K_ORI:           return 3'b110;
      K_AND, K_ANDI:         return 3'b111;
      default:               return 3'b000;
    endcase
  endfunction

  function automatic logic [31:0] encode(test_t t);
    logic [6:0] f7;
    f7 = (t.kind == K_SUB) ? 7'b0100000 : 7'b0000000;
    if (t.kind <= K_SLT) begin
      return {f7, t.rs2, t.rs1, funct3_of(t.kind), t.rd, 7'b0110011};
    end
    // LOAD major opcode, outside the supported set
    if (t.kind == K_LOAD) begin
      return {t.imm, t.rs1, funct3_of(t.kind), t.rd, 7'b0000011};
    end
    return {t.imm, t.rs1, funct3_of(t.kind), t.rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] alu_ref(logic [3:0] kind, logic [31:0] a, logic [31:0] b);
    case (kind)
      K_ADD, K_ADDI: return a + b;
      K_SUB:         return a - b;
      K_AND, K_ANDI: return a & b;
      K_OR, K_ORI:   return a | b;
      K_XOR, K_XORI: return a ^ b;
      default:       return {31'b0, $signed(a) < $signed(b)};
    endcase
  endfunction

  function automatic string fmt_entry(result_entry_t e);
    return $sformatf("pc=%h rd=%0d wr=%b ill=%b res=%h tval=%h",
                     e.pc, e.rd, e.writes_rd, e.illegal, e.result, e.tval);
  endfunction

  task automatic add_test(string name, logic [3:0] kind, int rd, int rs1, int rs2, int imm);
    tests.push_back('{kind, 5'(rd), 5'(rs1), 5'(rs2), 12'(imm)});
    names.push_back(name);
  endtask

  task automatic report_mismatch(string name, result_entry_t exp, result_entry_t act);
    $display("FAIL %s: expected %s, actual %s", name, fmt_entry(exp), fmt_entry(act));
    $display("Simulation FAILED");
    $fatal(1, "commit report mismatch");
  endtask

  task automatic fail_plain(string msg);
    $display("ERROR: %s", msg);
    $display("Simulation FAILED");
    $fatal(1, "check failed");
  endtask

  // ------------------------------------------------------------------
  // stimulus table and register model
  // ------------------------------------------------------------------
  task automatic load_table();
    add_test("addi_pos", K_ADDI, 1, 0, 0, 5);
    add_test("addi_neg", K_ADDI, 2, 0, 0, -3);
    add_test("add", K_ADD, 3, 1, 2, 0);
    add_test("sub", K_SUB, 4, 1, 2, 0);
    add_test("and", K_AND, 5, 1, 2, 0);
    add_test("or", K_OR, 6, 1, 2, 0);
    add_test("xor", K_XOR, 7, 1, 2, 0);
    add_test("slt_true", K_SLT, 8, 2, 1, 0);
    add_test("slt_false", K_SLT, 9, 1, 2, 0);
    add_test("andi", K_ANDI, 10, 2, 0, 'h0f0);
    add_test("ori_signext", K_ORI, 11, 1, 0, -2048);
    add_test("xori", K_XORI, 12, 2, 0, 'h7ff);
    add_test("slti_true", K_SLTI, 13, 2, 0, 0);
    add_test("slti_false", K_SLTI, 14, 1, 0, -1);
    add_test("chain_addi", K_ADDI, 15, 15, 0, 1);
    add_test("chain_add", K_ADD, 15, 15, 15, 0);
    add_test("chain_addi2", K_ADDI, 15, 15, 0, 7);
    add_test("chain_use", K_ADD, 16, 15, 1, 0);
    add_test("write_x0", K_ADDI, 0, 1, 0, 100);
    add_test("read_x0", K_ADD, 17, 0, 0, 0);
    add_test("illegal_load", K_LOAD, 16, 1, 0, 8);
    add_test("after_trap", K_ADDI, 18, 16, 0, 0);
    add_test("sub_from_x0", K_SUB, 19, 0, 16, 0);
    add_test("xor_dep", K_XOR, 20, 19, 16, 0);
  endtask

  task automatic build_expected();
    logic [XLEN-1:0] model [NR_REGS];
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    result_entry_t   e;
    test_t           t;
    foreach (model[r]) begin
      model[r] = '0;
    end
    foreach (tests[i]) begin
      t = tests[i];
      words.push_back(encode(t));
      a = model[t.rs1];
      b = (t.kind <= K_SLT) ? model[t.rs2] : {{20{t.imm[11]}}, t.imm};
      e.pc        = BOOT_ADDR + XLEN'(4 * i);
      e.rd        = t.rd;
      e.illegal   = (t.kind == K_LOAD);
      e.writes_rd = !e.illegal;
      e.result    = e.illegal ? '0 : alu_ref(t.kind, a, b);
      e.tval      = e.illegal ? words[i] : '0;
      // x0 stays zero, a trap changes no register
      if (e.writes_rd && t.rd != 0) begin
        model[t.rd] = e.result;
      end
      expected.push_back(e);
    end
  endtask

  // one lfsr for both handshakes, stepped in a fixed order per edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (instr_valid_i && instr_ready_o) begin
        sent = sent + 1;
      end
      if (!instr_valid_i || instr_ready_o) begin
        lfsr = lfsr_step(lfsr);
        gap  = lfsr[0];
        lfsr = lfsr_step(lfsr);
        gap  = gap & lfsr[0];
        instr_valid_i <= (sent < tests.size()) && !gap;
        instr_i       <= (sent < words.size()) ? words[sent] : '0;
      end
      lfsr  = lfsr_step(lfsr);
      stall = lfsr[0];
      lfsr  = lfsr_step(lfsr);
      commit_ready_i <= !(stall && lfsr[0]);
    end
  end

  // retire monitor
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      assert (!commit_valid_o) else fail_plain("commit_valid_o was high during reset");
    end else if (commit_valid_o) begin
      assert (took_any && retired < expected.size())
        else fail_plain("a commit report arrived with no instruction left to retire");
      if (commit_ready_i) begin
        assert (commit_o === expected[retired])
          else report_mismatch(names[retired], expected[retired], commit_o);
        retired = retired + 1;
      end
    end
    if (instr_valid_i && instr_ready_o) begin
      took_any = 1'b1;
    end
  end

  initial begin
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    instr_i        = '0;
    instr_valid_i  = 1'b0;
    commit_ready_i = 1'b0;
    sent           = 0;
    retired        = 0;
    took_any       = 1'b0;
    lfsr           = 32'hdcea;
    load_table();
    build_expected();
    limit = tests.size() * 20 + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    cycles = RESET_CYCLES;
    while (retired < tests.size() && cycles < limit) begin
      @(negedge clk_i);
      cycles++;
    end
    // idle tail, a stray extra report would show up here
    repeat (4) @(negedge clk_i);
    if (retired != tests.size()) begin
      $display("ERROR: timeout after %0d cycles, %0d of %0d instructions retired",
               cycles, retired, tests.size());
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
